// File: common/serv_config.svh
`ifndef SERV_CONFIG_SVH
`define SERV_CONFIG_SVH

// address of the first instruction fetch after reset.
`define SERV_RESET_PC 32'h0000_0000

// register RAM word width in bits, 2, 4 or 8.
`define SERV_RF_WIDTH 2

// 32 registers of 32 bits give 1024 bits, split into words of the RAM width.
`define SERV_RF_L2D $clog2(1024 / `SERV_RF_WIDTH)

// external multiply unit present when 1.
`define SERV_WITH_MDU 1

`endif

// File: common/serv_pkg.sv
`include "serv_config.svh"

package serv_pkg;

   typedef logic [31:0]                 word_t;
   typedef logic [4:0]                  gpr_idx_t;
   typedef logic [`SERV_RF_L2D-1:0]     rf_addr_t;
   typedef logic [`SERV_RF_WIDTH-1:0]   rf_word_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // register file request and response
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef struct packed {
      logic     rreq;    // one cycle pulse that starts a read of both operands.
      logic     wreq;    // high for every bit cycle of a write pass.
      gpr_idx_t rreg0;   // rs1 index.
      gpr_idx_t rreg1;   // rs2 index.
      gpr_idx_t wreg0;   // rd index.
      logic     wen0;    // the bits of this pass are committed.
      logic     wdata0;  // rd bit of the current cycle.
   } rf_req_t;

   typedef struct packed {
      logic ready;       // operand bits start on the next cycle.
      logic rdata0;      // rs1 bit, lsb first.
      logic rdata1;      // rs2 bit, lsb first.
   } rf_rsp_t;

   typedef struct packed {
      rf_addr_t waddr;
      rf_word_t wdata;
      logic     wen;
   } rf_wr_t;

   typedef struct packed {
      word_t      adr;
      word_t      dat;
      logic [3:0] sel;
      logic       we;
      logic       cyc;
   } dbus_req_t;

   typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR} alu_op_e;

   typedef enum logic [2:0] {IDLE, FETCH, DECODE, RREQ, EXEC, MEM, MDU} core_state_e;

endpackage

// File: design/core/serv_alu.sv
`timescale 1ns/100ps

module serv_alu (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  serv_pkg::alu_op_e i_op,
   input  logic              i_a,
   input  logic              i_b,
   input  logic              i_first,
   output logic              o_q
);

   logic is_sub;
   logic b_eff;
   logic cin;
   logic carry;
   logic sum;

   assign is_sub = (i_op == serv_pkg::SUB);
   assign b_eff  = i_b ^ is_sub;              // subtraction adds the inverted operand.
   assign cin    = i_first ? is_sub : carry;  // the +1 of two's complement enters on bit 0.
   assign sum    = i_a ^ b_eff ^ cin;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry <= 1'b0;
      end else begin
         carry <= (i_a & b_eff) | (cin & (i_a ^ b_eff));
      end
   end

   always_comb begin
      case (i_op)
         serv_pkg::AND: o_q = i_a & i_b;
         serv_pkg::OR:  o_q = i_a | i_b;
         serv_pkg::XOR: o_q = i_a ^ i_b;
         default:       o_q = sum;
      endcase
   end

endmodule

// File: design/core/serv_core.sv
`timescale 1ns/100ps
`include "serv_config.svh"

module serv_core (
   input  logic                i_clk,
   input  logic                i_rst_n,
   output serv_pkg::word_t     o_ibus_adr,
   output logic                o_ibus_cyc,
   input  serv_pkg::word_t     i_ibus_rdt,
   input  logic                i_ibus_ack,
   output serv_pkg::dbus_req_t o_dbus,
   input  serv_pkg::word_t     i_dbus_rdt,
   input  logic                i_dbus_ack,
   output serv_pkg::word_t     o_mdu_rs1,
   output logic [2:0]          o_mdu_op,
   output logic                o_mdu_valid,
   input  logic                i_mdu_ready,
   output serv_pkg::rf_req_t   o_rf_req,
   input  serv_pkg::rf_rsp_t   i_rf_rsp
);

   serv_pkg::core_state_e state;
   logic [4:0]            cnt;
   logic                  cnt_done;
   serv_pkg::word_t       insn;
   serv_pkg::word_t       pc;
   serv_pkg::word_t       rs1_buf;
   serv_pkg::word_t       rs2_buf;
   serv_pkg::word_t       adr_buf;
   serv_pkg::word_t       res_buf;
   serv_pkg::gpr_idx_t    rs1;
   serv_pkg::gpr_idx_t    rs2;
   serv_pkg::gpr_idx_t    rd;
   serv_pkg::alu_op_e     alu_op;
   logic                  use_imm;
   logic                  is_store;
   logic                  is_mul;
   logic                  rd_en;
   logic                  imm_bit;
   logic                  exec;
   logic                  shift_en;
   logic                  mdu_pass;
   logic                  alu_q;
   logic                  pc_q;
   logic                  dbus_cyc;

   assign exec     = (state == serv_pkg::EXEC);
   assign shift_en = exec && !mdu_pass;  // operand pass, not the product write-back.

   serv_state u_state (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_rsp.ready),
      .i_is_store (is_store),
      .i_is_mul   (is_mul),
      .i_dbus_ack (i_dbus_ack),
      .o_state    (state),
      .o_cnt      (cnt),
      .o_cnt_done (cnt_done)
   );

   serv_decode u_decode (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_insn      (insn),
      .i_shift_imm (shift_en),
      .o_rs1       (rs1),
      .o_rs2       (rs2),
      .o_rd        (rd),
      .o_alu_op    (alu_op),
      .o_use_imm   (use_imm),
      .o_is_store  (is_store),
      .o_is_mul    (is_mul),
      .o_rd_en     (rd_en),
      .o_imm_bit   (imm_bit)
   );

   serv_alu u_alu (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_op    (alu_op),
      .i_a     (i_rf_rsp.rdata0),
      .i_b     (use_imm ? imm_bit : i_rf_rsp.rdata1),
      .i_first (cnt == 5'd0),
      .o_q     (alu_q)
   );

   // second adder instance advances the PC by 4 while it rotates.
   serv_alu u_pc_alu (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_op    (serv_pkg::ADD),
      .i_a     (pc[0]),
      .i_b     (cnt == 5'd2),
      .i_first (cnt == 5'd0),
      .o_q     (pc_q)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // sequencing and bus requests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc          <= `SERV_RESET_PC;
         dbus_cyc    <= 1'b0;
         o_mdu_valid <= 1'b0;
         mdu_pass    <= 1'b0;
      end else begin
         if (shift_en) pc <= {pc_q, pc[31:1]};

         if (exec && cnt_done && is_store) dbus_cyc <= 1'b1;  // address is complete now.
         else if (i_dbus_ack) dbus_cyc <= 1'b0;

         if (shift_en && cnt_done && is_mul) o_mdu_valid <= 1'b1;
         else if (i_mdu_ready) o_mdu_valid <= 1'b0;

         if (o_mdu_valid && i_mdu_ready) mdu_pass <= 1'b1;
         else if (exec && cnt_done) mdu_pass <= 1'b0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (o_ibus_cyc && i_ibus_ack) insn <= i_ibus_rdt;
      if (shift_en) begin
         rs1_buf <= {i_rf_rsp.rdata0, rs1_buf[31:1]};
         rs2_buf <= {i_rf_rsp.rdata1, rs2_buf[31:1]};
         adr_buf <= {alu_q, adr_buf[31:1]};
      end
      if (o_mdu_valid && i_mdu_ready) res_buf <= i_dbus_rdt;  // product from the top-level mux.
      else if (exec && mdu_pass) res_buf <= res_buf >> 1;
   end

   assign o_ibus_cyc = (state == serv_pkg::FETCH);
   assign o_ibus_adr = pc;

   assign o_dbus.adr = adr_buf;
   assign o_dbus.dat = rs2_buf;
   assign o_dbus.sel = 4'b1111;
   assign o_dbus.we  = 1'b1;
   assign o_dbus.cyc = dbus_cyc;

   assign o_mdu_rs1 = rs1_buf;
   assign o_mdu_op  = insn[14:12];

   assign o_rf_req.rreq   = (state == serv_pkg::RREQ) && (cnt == 5'd0);
   assign o_rf_req.wreq   = exec;
   assign o_rf_req.rreg0  = rs1;
   assign o_rf_req.rreg1  = rs2;
   assign o_rf_req.wreg0  = rd;
   assign o_rf_req.wen0   = rd_en && (!is_mul || mdu_pass);  // MUL writes only its product.
   assign o_rf_req.wdata0 = mdu_pass ? res_buf[0] : alu_q;

   // a store and a multiply never request at the same time.
   a_one_request: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(o_dbus.cyc && o_mdu_valid));

endmodule

// File: design/core/serv_decode.sv
`timescale 1ns/100ps
`include "serv_config.svh"

module serv_decode (
   input  logic               i_clk,
   input  logic               i_rst_n,
   input  serv_pkg::word_t    i_insn,
   input  logic               i_shift_imm,
   output serv_pkg::gpr_idx_t o_rs1,
   output serv_pkg::gpr_idx_t o_rs2,
   output serv_pkg::gpr_idx_t o_rd,
   output serv_pkg::alu_op_e  o_alu_op,
   output logic               o_use_imm,
   output logic               o_is_store,
   output logic               o_is_mul,
   output logic               o_rd_en,
   output logic               o_imm_bit
);

   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic        is_op_imm;
   logic        is_op;
   logic [11:0] imm;
   logic [11:0] imm_sr;

   assign opcode    = i_insn[6:0];
   assign funct3    = i_insn[14:12];
   assign funct7    = i_insn[31:25];
   assign is_op_imm = (opcode == 7'b0010011);
   assign is_op     = (opcode == 7'b0110011);

   assign o_rs1      = i_insn[19:15];
   assign o_rs2      = i_insn[24:20];
   assign o_rd       = i_insn[11:7];
   assign o_is_store = (opcode == 7'b0100011);
   assign o_is_mul   = (`SERV_WITH_MDU != 0) && is_op && (funct7 == 7'b0000001);
   assign o_use_imm  = !is_op;              // immediate operand for ADDI and the store address.
   assign o_rd_en    = is_op_imm | is_op;

   // S-type splits the immediate around the rd field.
   assign imm = o_is_store ? {funct7, i_insn[11:7]} : i_insn[31:20];

   always_comb begin
      case (funct3)
         3'b100:  o_alu_op = serv_pkg::XOR;
         3'b110:  o_alu_op = serv_pkg::OR;
         3'b111:  o_alu_op = serv_pkg::AND;
         default: o_alu_op = (is_op && funct7[5]) ? serv_pkg::SUB : serv_pkg::ADD;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         imm_sr <= '0;
      end else if (i_shift_imm) begin
         imm_sr <= {imm_sr[11], imm_sr[11:1]};  // the sign bit repeats above bit 11.
      end else begin
         imm_sr <= imm;
      end
   end

   assign o_imm_bit = imm_sr[0];

endmodule

// File: design/core/serv_state.sv
`timescale 1ns/100ps

module serv_state (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_ibus_ack,
   input  logic                  i_rf_ready,
   input  logic                  i_is_store,
   input  logic                  i_is_mul,
   input  logic                  i_dbus_ack,
   output serv_pkg::core_state_e o_state,
   output logic [4:0]            o_cnt,
   output logic                  o_cnt_done
);

   logic mdu_done;  // the multiply result pass has been entered.

   assign o_cnt_done = (o_cnt == 5'd31);

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_state  <= serv_pkg::IDLE;
         o_cnt    <= '0;
         mdu_done <= 1'b0;
      end else begin
         // the counter runs through RREQ and EXEC and rests at zero elsewhere.
         if (o_state == serv_pkg::EXEC || (o_state == serv_pkg::RREQ && !i_rf_ready)) begin
            o_cnt <= o_cnt + 5'd1;
         end else begin
            o_cnt <= '0;
         end

         case (o_state)
            serv_pkg::IDLE: o_state <= serv_pkg::FETCH;
            serv_pkg::FETCH: begin
               mdu_done <= 1'b0;
               if (i_ibus_ack) o_state <= serv_pkg::DECODE;
            end
            serv_pkg::DECODE: o_state <= serv_pkg::RREQ;
            serv_pkg::RREQ: begin
               if (i_rf_ready) o_state <= serv_pkg::EXEC;
            end
            serv_pkg::EXEC: begin
               if (o_cnt_done) begin
                  if (mdu_done) o_state <= serv_pkg::FETCH;
                  else if (i_is_store) o_state <= serv_pkg::MEM;
                  else if (i_is_mul) o_state <= serv_pkg::MDU;
                  else o_state <= serv_pkg::FETCH;
               end
            end
            serv_pkg::MEM: begin
               if (i_dbus_ack) o_state <= serv_pkg::FETCH;
            end
            serv_pkg::MDU: begin
               if (i_dbus_ack) begin
                  o_state  <= serv_pkg::EXEC;  // a second pass shifts the product into rd.
                  mdu_done <= 1'b1;
               end
            end
            default: o_state <= serv_pkg::IDLE;
         endcase
      end
   end

endmodule

// File: design/rf/serv_rf_ram.sv
`timescale 1ns/100ps
`include "serv_config.svh"

module serv_rf_ram (
   input  logic               i_clk,
   input  serv_pkg::rf_wr_t   i_wr,
   input  serv_pkg::rf_addr_t i_raddr,
   output serv_pkg::rf_word_t o_rdata
);

   serv_pkg::rf_word_t mem [2**`SERV_RF_L2D];

   always_ff @(posedge i_clk) begin
      if (i_wr.wen) mem[i_wr.waddr] <= i_wr.wdata;
      o_rdata <= mem[i_raddr];  // data follows the address by one cycle.
   end

   a_known_waddr: assert property (@(posedge i_clk)
      i_wr.wen |-> !$isunknown(i_wr.waddr));

endmodule

// File: design/rf/serv_rf_ram_if.sv
`timescale 1ns/100ps
`include "serv_config.svh"

module serv_rf_ram_if (
   input  logic                i_clk,
   input  logic                i_rst_n,
   input  serv_pkg::rf_req_t   i_req,
   output serv_pkg::rf_rsp_t   o_rsp,
   output serv_pkg::rf_wr_t    o_wr,
   output serv_pkg::rf_addr_t  o_raddr,
   input  serv_pkg::rf_word_t  i_rdata
);

   localparam int W  = `SERV_RF_WIDTH;
   localparam int WB = $clog2(W);

   logic [5:0]         cnt;     // read sequence position, zero when idle.
   logic               capture;
   logic               load;
   serv_pkg::gpr_idx_t rreg;
   serv_pkg::rf_word_t stage0;  // rs1 word waiting for its slot.
   serv_pkg::rf_word_t sr0;
   serv_pkg::rf_word_t sr1;
   logic [4:0]         wcnt;
   logic               wlast;
   serv_pkg::rf_word_t wsr;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // read side
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt <= '0;
      end else if (i_req.rreq) begin
         cnt <= 6'd1;
      end else if (cnt == 6'd34) begin
         cnt <= '0;                    // the last of the 32 bit cycles.
      end else if (cnt != '0) begin
         cnt <= cnt + 6'd1;
      end
   end

   // rs1 word k is addressed at cnt = W*k and rs2 word k one cycle later.
   assign rreg    = cnt[0] ? i_req.rreg1 : i_req.rreg0;
   assign o_raddr = {rreg, cnt[4:WB]};

   assign capture = (cnt != '0) && (cnt[WB-1:0] == WB'(1));
   assign load    = (cnt >= 6'd2) && (cnt <= 6'(34 - W)) && (cnt[WB-1:0] == WB'(2 % W));

   always_ff @(posedge i_clk) begin
      if (capture) stage0 <= i_rdata;
      if (load) begin
         sr0 <= stage0;
         sr1 <= i_rdata;               // rs2 word arrives just in time.
      end else begin
         sr0 <= sr0 >> 1;
         sr1 <= sr1 >> 1;
      end
   end

   assign o_rsp.ready  = (cnt == 6'd2);
   assign o_rsp.rdata0 = sr0[0] & (|i_req.rreg0);  // x0 reads as zero.
   assign o_rsp.rdata1 = sr1[0] & (|i_req.rreg1);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // write side
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wcnt <= '0;
      end else if (i_req.wreq) begin
         wcnt <= wcnt + 5'd1;          // wraps after each 32-bit pass.
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_req.wreq) wsr <= {i_req.wdata0, wsr[W-1:1]};
   end

   assign wlast = i_req.wreq && (wcnt[WB-1:0] == '1);

   assign o_wr.waddr = {i_req.wreg0, wcnt[4:WB]};
   assign o_wr.wdata = {i_req.wdata0, wsr[W-1:1]};
   assign o_wr.wen   = wlast && i_req.wen0 && (|i_req.wreg0);  // x0 is never written.

   // a read request only starts while no read sequence runs, so ready follows it.
   a_rreq_when_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_req.rreq |-> (cnt == '0));

endmodule

// File: design/serv_rf_top.sv
`timescale 1ns/100ps
`include "serv_config.svh"

module serv_rf_top (
   input  logic            clk,
   input  logic            i_rst_n,
   output serv_pkg::word_t o_ibus_adr,
   output logic            o_ibus_cyc,
   input  serv_pkg::word_t i_ibus_rdt,
   input  logic            i_ibus_ack,
   output serv_pkg::word_t o_dbus_adr,
   output serv_pkg::word_t o_dbus_dat,
   output logic [3:0]      o_dbus_sel,
   output logic            o_dbus_we,
   output logic            o_dbus_cyc,
   input  logic            i_dbus_ack,
   output serv_pkg::word_t o_ext_mdu_rs1,
   output serv_pkg::word_t o_ext_mdu_rs2,
   output logic [2:0]      o_ext_mdu_op,
   output logic            o_ext_mdu_valid,
   input  serv_pkg::word_t i_ext_mdu_rd,
   input  logic            i_ext_mdu_ready
);

   serv_pkg::rf_req_t   rf_req;
   serv_pkg::rf_rsp_t   rf_rsp;
   serv_pkg::rf_wr_t    rf_wr;
   serv_pkg::rf_addr_t  raddr;
   serv_pkg::rf_word_t  rdata;
   serv_pkg::dbus_req_t dbus;
   serv_pkg::word_t     dbus_rdt;
   logic                dbus_ack;
   logic                mdu_ack;

   // the product returns on the data read path, stores have no read data.
   assign mdu_ack  = (`SERV_WITH_MDU != 0) && i_ext_mdu_ready;
   assign dbus_rdt = mdu_ack ? i_ext_mdu_rd : '0;
   assign dbus_ack = i_dbus_ack | mdu_ack;

   serv_core u_core (
      .i_clk       (clk),
      .i_rst_n     (i_rst_n),
      .o_ibus_adr  (o_ibus_adr),
      .o_ibus_cyc  (o_ibus_cyc),
      .i_ibus_rdt  (i_ibus_rdt),
      .i_ibus_ack  (i_ibus_ack),
      .o_dbus      (dbus),
      .i_dbus_rdt  (dbus_rdt),
      .i_dbus_ack  (dbus_ack),
      .o_mdu_rs1   (o_ext_mdu_rs1),
      .o_mdu_op    (o_ext_mdu_op),
      .o_mdu_valid (o_ext_mdu_valid),
      .i_mdu_ready (i_ext_mdu_ready),
      .o_rf_req    (rf_req),
      .i_rf_rsp    (rf_rsp)
   );

   serv_rf_ram_if u_rf_ram_if (
      .i_clk   (clk),
      .i_rst_n (i_rst_n),
      .i_req   (rf_req),
      .o_rsp   (rf_rsp),
      .o_wr    (rf_wr),
      .o_raddr (raddr),
      .i_rdata (rdata)
   );

   serv_rf_ram u_rf_ram (
      .i_clk   (clk),
      .i_wr    (rf_wr),
      .i_raddr (raddr),
      .o_rdata (rdata)
   );

   assign o_dbus_adr    = dbus.adr;
   assign o_dbus_dat    = dbus.dat;
   assign o_dbus_sel    = dbus.sel;
   assign o_dbus_we     = dbus.we;
   assign o_dbus_cyc    = dbus.cyc;
   assign o_ext_mdu_rs2 = dbus.dat;  // rs2 shares the store data buffer.

endmodule

// File: tb.f
+incdir+common
common/serv_pkg.sv
design/rf/serv_rf_ram.sv
design/rf/serv_rf_ram_if.sv
design/core/serv_alu.sv
design/core/serv_decode.sv
design/core/serv_state.sv
design/core/serv_core.sv
design/serv_rf_top.sv
verification/tb_serv_rf_top.sv

// File: verification/tb_serv_rf_top.sv
`timescale 1ns/100ps
`include "serv_config.svh"

module tb_serv_rf_top;

   localparam int NKIND         = 8;
   localparam int NROWS         = 16;
   localparam int PROG_WORDS    = 128;
   localparam int STORE_TIMEOUT = 2000;

   typedef enum logic [3:0] {K_ADDI, K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_MUL, K_X0} kind_e;

   // one row is a five word program and the two stores it must produce.
   typedef struct packed {
      kind_e           kind;
      logic [11:0]     imm_a;
      logic [11:0]     imm_b;
      logic [11:0]     off;
      serv_pkg::word_t adr0;
      serv_pkg::word_t dat0;
      serv_pkg::word_t adr1;
      serv_pkg::word_t dat1;
   } test_row_t;

   logic            clk;
   logic            i_rst_n;
   serv_pkg::word_t o_ibus_adr;
   logic            o_ibus_cyc;
   serv_pkg::word_t i_ibus_rdt;
   logic            i_ibus_ack;
   serv_pkg::word_t o_dbus_adr;
   serv_pkg::word_t o_dbus_dat;
   logic [3:0]      o_dbus_sel;
   logic            o_dbus_we;
   logic            o_dbus_cyc;
   logic            i_dbus_ack;
   serv_pkg::word_t o_ext_mdu_rs1;
   serv_pkg::word_t o_ext_mdu_rs2;
   logic [2:0]      o_ext_mdu_op;
   logic            o_ext_mdu_valid;
   serv_pkg::word_t i_ext_mdu_rd;
   logic            i_ext_mdu_ready;

   test_row_t       rows [NROWS];
   serv_pkg::word_t prog [PROG_WORDS];
   serv_pkg::word_t st_adr [$];     // stores seen by the dbus model, in order.
   serv_pkg::word_t st_dat [$];
   serv_pkg::word_t mdu_a [$];      // operands seen by the multiply model, in order.
   serv_pkg::word_t mdu_b [$];
   logic [31:0]     lcg_state;
   serv_pkg::word_t fetch_pc;
   int              bad_fetches;
   int              errors;
   int              run;
   int              failed;
   logic            timed_out;

   serv_rf_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // helpers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [15:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[30:15];
   endfunction

   function automatic serv_pkg::word_t sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic serv_pkg::word_t enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
      return {imm, rs1, 3'b000, rd, 7'b0010011};
   endfunction

   // register ops always read x1 and x2.
   function automatic serv_pkg::word_t enc_op(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [4:0] rd);
      return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
   endfunction

   function automatic serv_pkg::word_t enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                              input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic serv_pkg::word_t op_word(input kind_e k, input logic [11:0] imm);
      case (k)
         K_ADDI:  return enc_addi(5'd3, 5'd0, imm);
         K_ADD:   return enc_op(7'h00, 3'b000, 5'd3);
         K_SUB:   return enc_op(7'h20, 3'b000, 5'd3);
         K_AND:   return enc_op(7'h00, 3'b111, 5'd3);
         K_OR:    return enc_op(7'h00, 3'b110, 5'd3);
         K_XOR:   return enc_op(7'h00, 3'b100, 5'd3);
         K_MUL:   return enc_op(7'h01, 3'b000, 5'd3);
         default: return enc_op(7'h00, 3'b000, 5'd0);  // add into x0.
      endcase
   endfunction

   function automatic serv_pkg::word_t op_result(input kind_e k, input serv_pkg::word_t x1,
                                                 input serv_pkg::word_t x2);
      case (k)
         K_ADDI:  return x2;  // same sign-extended immediate as x2.
         K_ADD:   return x1 + x2;
         K_SUB:   return x1 - x2;
         K_AND:   return x1 & x2;
         K_OR:    return x1 | x2;
         K_XOR:   return x1 ^ x2;
         K_MUL:   return (`SERV_WITH_MDU != 0) ? x1 * x2 : x1 + x2;
         default: return '0;  // x0 reads back as zero.
      endcase
   endfunction

   function automatic string kind_name(input kind_e k);
      case (k)
         K_ADDI:  return "addi";
         K_ADD:   return "add";
         K_SUB:   return "sub";
         K_AND:   return "and";
         K_OR:    return "or";
         K_XOR:   return "xor";
         K_MUL:   return "mul";
         default: return "x0 write";
      endcase
   endfunction

   function automatic serv_pkg::word_t fetch_word(input serv_pkg::word_t adr);
      serv_pkg::word_t idx;
      idx = (adr - `SERV_RESET_PC) >> 2;
      if (idx < PROG_WORDS) begin
         return prog[idx];
      end else begin
         return 32'h0000_0013;  // nop past the end of the program.
      end
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         errors++;
      end
   endtask

   task automatic wait_for_stores(input int need);
      int n;
      n = 0;
      while (st_adr.size() < need && n < STORE_TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (st_adr.size() < need) begin
         $display("timeout: the DUT made no store within %0d cycles", STORE_TIMEOUT);
         timed_out = 1'b1;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      run++;
      if (errors != errs_before || timed_out) begin
         failed++;
         $display("test %0d %s: mismatch", run, name);
      end else begin
         $display("test %0d %s: ok", run, name);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // bus and multiply models
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin : ibus_model
      int wait_left;
      wait_left = -1;
      forever begin
         @(posedge clk);
         #2;
         if (i_ibus_ack) begin
            i_ibus_ack = 1'b0;  // one ack per request.
            wait_left = -1;
         end else if (o_ibus_cyc) begin
            if (wait_left < 0) wait_left = next_rand() % 4;
            if (wait_left == 0) begin
               if (o_ibus_adr !== fetch_pc) bad_fetches++;
               check_value(o_ibus_adr, fetch_pc, "fetch address");
               fetch_pc = fetch_pc + 32'd4;
               i_ibus_rdt = fetch_word(o_ibus_adr);
               i_ibus_ack = 1'b1;
            end else begin
               wait_left--;
            end
         end
      end
   end

   initial begin : dbus_model
      int              wait_left;
      serv_pkg::word_t first_adr;
      serv_pkg::word_t first_dat;
      wait_left = -1;
      forever begin
         @(posedge clk);
         #2;
         if (i_dbus_ack) begin
            i_dbus_ack = 1'b0;
            wait_left = -1;
         end else if (o_dbus_cyc) begin
            if (wait_left < 0) begin
               wait_left = next_rand() % 4;
               first_adr = o_dbus_adr;  // the request must hold until ack.
               first_dat = o_dbus_dat;
            end
            if (wait_left == 0) begin
               check_value(o_dbus_adr, first_adr, "store address held");
               check_value(o_dbus_dat, first_dat, "store data held");
               check_value(o_dbus_sel, 4'hf, "store byte select");
               check_value(o_dbus_we, 1'b1, "store write enable");
               st_adr.push_back(o_dbus_adr);
               st_dat.push_back(o_dbus_dat);
               i_dbus_ack = 1'b1;
            end else begin
               wait_left--;
            end
         end
      end
   end

   initial begin : mdu_model
      int              wait_left;
      serv_pkg::word_t op_a;
      serv_pkg::word_t op_b;
      wait_left = -1;
      forever begin
         @(posedge clk);
         #2;
         if (i_ext_mdu_ready) begin
            i_ext_mdu_ready = 1'b0;
            wait_left = -1;
         end else if (o_ext_mdu_valid) begin
            if (wait_left < 0) begin
               wait_left = next_rand() % 4;
               op_a = o_ext_mdu_rs1;
               op_b = o_ext_mdu_rs2;
            end
            if (wait_left == 0) begin
               check_value(o_ext_mdu_rs1, op_a, "mdu rs1 held");
               check_value(o_ext_mdu_rs2, op_b, "mdu rs2 held");
               check_value(o_ext_mdu_op, 3'b000, "mdu funct3");
               mdu_a.push_back(o_ext_mdu_rs1);
               mdu_b.push_back(o_ext_mdu_rs2);
               i_ext_mdu_rd = op_a * op_b;  // low half of the product.
               i_ext_mdu_ready = 1'b1;
            end else begin
               wait_left--;
            end
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // table build, reset and checks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin : main
      serv_pkg::word_t x1;
      serv_pkg::word_t x2;
      serv_pkg::word_t got_adr;
      serv_pkg::word_t got_dat;
      logic [15:0]     r;
      int              n;
      int              errs_before;

      i_rst_n         = 1'b0;
      i_ibus_rdt      = '0;
      i_ibus_ack      = 1'b0;
      i_dbus_ack      = 1'b0;
      i_ext_mdu_rd    = '0;
      i_ext_mdu_ready = 1'b0;
      lcg_state       = 32'd40;
      fetch_pc        = `SERV_RESET_PC;
      bad_fetches     = 0;
      errors          = 0;
      run             = 0;
      failed          = 0;
      timed_out       = 1'b0;

      for (n = 0; n < PROG_WORDS; n++) begin
         prog[n] = enc_addi(5'd0, 5'd0, n[11:0]);  // each unused slot carries its index.
      end
      for (n = 0; n < NROWS; n++) begin
         rows[n].kind = kind_e'(n % NKIND);
         r = next_rand();
         rows[n].imm_a = r[11:0];
         r = next_rand();
         rows[n].imm_b = r[11:0];
         r = next_rand();
         rows[n].off = r[11:0];
         if (n == K_ADDI) rows[n].imm_b[11] = 1'b1;  // negative immediate.
         if (n == K_ADD) begin
            rows[n].imm_a = 12'hfff;  // the carry runs through all 32 bits.
            rows[n].imm_b = 12'h001;
         end
         if (n == K_SUB) begin
            rows[n].imm_a = 12'h001;  // borrow into every upper bit.
            rows[n].imm_b = 12'h002;
         end
         x1 = sext12(rows[n].imm_a);
         x2 = sext12(rows[n].imm_b);
         rows[n].adr0 = x1 + sext12(rows[n].off);
         rows[n].dat0 = op_result(rows[n].kind, x1, x2);
         rows[n].adr1 = x2;
         rows[n].dat1 = x1;
         prog[5*n]     = enc_addi(5'd1, 5'd0, rows[n].imm_a);
         prog[5*n + 1] = enc_addi(5'd2, 5'd0, rows[n].imm_b);
         prog[5*n + 2] = op_word(rows[n].kind, rows[n].imm_b);
         prog[5*n + 3] = enc_sw((rows[n].kind == K_X0) ? 5'd0 : 5'd3, 5'd1, rows[n].off);
         prog[5*n + 4] = enc_sw(5'd1, 5'd2, 12'h000);
      end

      repeat (3) @(posedge clk);
      #2;
      i_rst_n = 1'b1;

      errs_before = errors;
      check_value(o_dbus_cyc, 1'b0, "dbus cyc after reset");
      check_value(o_ext_mdu_valid, 1'b0, "mdu valid after reset");
      n = 0;
      while (!o_ibus_cyc && n < 10) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!o_ibus_cyc) begin
         $display("timeout: o_ibus_cyc never rose after reset");
         timed_out = 1'b1;
      end
      check_value(n, 1, "cycles to first fetch");
      check_value(o_ibus_adr, `SERV_RESET_PC, "first fetch address");
      report_test("reset", errs_before);

      for (n = 0; n < NROWS && !timed_out; n++) begin
         errs_before = errors;
         wait_for_stores(2);
         if (!timed_out) begin
            if (rows[n].kind == K_MUL && `SERV_WITH_MDU != 0) begin
               check_value(mdu_a.size(), 1, "multiply requests");
               if (mdu_a.size() > 0) begin
                  got_adr = mdu_a.pop_front();
                  got_dat = mdu_b.pop_front();
                  check_value(got_adr, sext12(rows[n].imm_a), "mdu rs1 operand");
                  check_value(got_dat, sext12(rows[n].imm_b), "mdu rs2 operand");
               end
            end
            got_adr = st_adr.pop_front();
            got_dat = st_dat.pop_front();
            check_value(got_adr, rows[n].adr0, "result store address");
            check_value(got_dat, rows[n].dat0, "result store data");
            got_adr = st_adr.pop_front();
            got_dat = st_dat.pop_front();
            check_value(got_adr, rows[n].adr1, "operand store address");
            check_value(got_dat, rows[n].dat1, "operand store data");
         end
         report_test(kind_name(rows[n].kind), errs_before);
      end

      errs_before = errors;
      check_value(bad_fetches, 0, "out of order fetches");
      check_value(st_adr.size(), 0, "stores left over");
      check_value(mdu_a.size(), 0, "multiply requests left over");
      report_test("fetch order", errs_before);

      $display("tests run %0d, failed %0d, errors %0d", run, failed, errors);
      if (failed == 0 && errors == 0 && !timed_out) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
